/* src/keypad_pkg.sv */
package keypad_pkg;

    // pads sharing one event FIFO
    localparam int num_pads = 2;

    // row index times four plus column index
    localparam int key_code_w = 4;

    // pad index on top of the key code
    localparam int event_w = 5;

    localparam int fifo_depth = 8;

    // 20 ms at 100 MHz
    localparam int default_debounce_cycles = 2_000_000;

    // pull-ups hold every row high
    localparam logic [3:0] rows_idle = 4'hf;

endpackage

/* src/keypad_scanner.sv */
`timescale 1ns/10ps

module keypad_scanner #(
    parameter int debounce_cycles = keypad_pkg::default_debounce_cycles
) (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic [3:0]                      row,
    output logic [3:0]                      col,
    output logic                            key_valid,
    output logic [keypad_pkg::key_code_w-1:0] key_code
);
    import keypad_pkg::*;

    localparam int cnt_w = (debounce_cycles > 1) ? $clog2(debounce_cycles) : 1;

    typedef enum logic [2:0] {
        st_idle,
        st_scan1,
        st_wait,
        st_scan2,
        st_compare,
        st_release
    } state_t;

    state_t state;

    logic [1:0]            col_idx;
    logic [cnt_w-1:0]      cnt;
    logic [1:0]            row_idx;
    logic                  hit;
    logic [key_code_w-1:0] hit_code;
    logic [key_code_w-1:0] code1;
    logic [key_code_w-1:0] code2;

    // one column low while sweeping, all low otherwise so any press shows
    always_comb begin
        if (state == st_scan1 || state == st_scan2) begin
            col = ~(4'b0001 << col_idx);
        end else begin
            col = 4'b0000;
        end
    end

    // lowest pulled-down row wins
    always_comb begin
        row_idx = 2'd0;
        for (int r = 3; r >= 0; r--) begin
            if (!row[r]) begin
                row_idx = 2'(r);
            end
        end
    end

    assign hit      = (row != rows_idle);
    assign hit_code = {row_idx, col_idx};

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state     <= st_idle;
            col_idx   <= 2'd0;
            cnt       <= '0;
            key_valid <= 1'b0;
        end else begin
            key_valid <= 1'b0;
            case (state)
                st_idle: begin
                    if (hit) begin
                        state   <= st_scan1;
                        col_idx <= 2'd0;
                    end
                end
                st_scan1: begin
                    if (hit) begin
                        state <= st_wait;
                        cnt   <= '0;
                    end else if (col_idx == 2'd3) begin
                        state <= st_idle;  // nothing found on any column
                    end else begin
                        col_idx <= col_idx + 2'd1;
                    end
                end
                st_wait: begin
                    if (!hit) begin
                        state <= st_idle;  // bounced open
                    end else if (cnt == cnt_w'(debounce_cycles - 1)) begin
                        state   <= st_scan2;
                        col_idx <= 2'd0;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                st_scan2: begin
                    if (hit) begin
                        state <= st_compare;
                    end else if (col_idx == 2'd3) begin
                        state <= st_idle;
                    end else begin
                        col_idx <= col_idx + 2'd1;
                    end
                end
                st_compare: begin
                    if (code1 == code2) begin
                        key_valid <= 1'b1;
                        state     <= st_release;
                    end else begin
                        state <= st_idle;
                    end
                end
                st_release: begin
                    if (!hit) begin
                        state <= st_idle;  // held key reports once
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    // captured codes of both sweeps
    always_ff @(posedge clk) begin
        if (state == st_scan1 && hit) begin
            code1 <= hit_code;
        end
        if (state == st_scan2 && hit) begin
            code2 <= hit_code;
        end
        if (state == st_compare) begin
            key_code <= code1;
        end
    end

endmodule

/* src/key_event_arbiter.sv */
`timescale 1ns/10ps

module key_event_arbiter (
    input  logic                                                      clk,
    input  logic                                                      rst_n,
    input  logic [keypad_pkg::num_pads-1:0]                           key_valid,
    input  logic [keypad_pkg::num_pads-1:0][keypad_pkg::key_code_w-1:0] key_code,
    output logic                                                      wr_en,
    output logic [keypad_pkg::event_w-1:0]                            wr_data
);
    import keypad_pkg::*;

    localparam int pad_w = event_w - key_code_w;

    logic [num_pads-1:0]                 pending;
    logic [num_pads-1:0][key_code_w-1:0] pend_code;
    logic [pad_w-1:0]                    ptr;
    logic [pad_w-1:0]                    grant_idx;
    logic                                grant_found;

    // first pending pad at or after the pointer
    always_comb begin
        int cand;
        cand        = 0;
        grant_found = 1'b0;
        grant_idx   = '0;
        for (int i = 0; i < num_pads; i++) begin
            cand = int'(ptr) + i;
            if (cand >= num_pads) begin
                cand = cand - num_pads;
            end
            if (!grant_found && pending[cand]) begin
                grant_found = 1'b1;
                grant_idx   = pad_w'(cand);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pending <= '0;
            ptr     <= '0;
        end else begin
            for (int p = 0; p < num_pads; p++) begin
                if (key_valid[p]) begin
                    pending[p] <= 1'b1;  // new strobe beats the grant
                end else if (grant_found && int'(grant_idx) == p) begin
                    pending[p] <= 1'b0;
                end
            end
            if (grant_found) begin
                ptr <= (grant_idx == pad_w'(num_pads - 1)) ? '0 : grant_idx + pad_w'(1);
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int p = 0; p < num_pads; p++) begin
            if (key_valid[p]) begin
                pend_code[p] <= key_code[p];
            end
        end
    end

    assign wr_en   = grant_found;
    assign wr_data = {grant_idx, pend_code[grant_idx]};  // pad tag above code

endmodule

/* src/key_event_fifo.sv */
`timescale 1ns/10ps

module key_event_fifo (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            wr_en,
    input  logic [keypad_pkg::event_w-1:0]  wr_data,
    input  logic                            rd_en,
    output logic [keypad_pkg::event_w-1:0]  rd_data,
    output logic                            empty,
    output logic                            overflow
);
    import keypad_pkg::*;

    localparam int ptr_w = (fifo_depth > 1) ? $clog2(fifo_depth) : 1;
    localparam int cnt_w = $clog2(fifo_depth + 1);

    logic [event_w-1:0] mem [fifo_depth];
    logic [ptr_w-1:0]   wr_ptr;
    logic [ptr_w-1:0]   rd_ptr;
    logic [cnt_w-1:0]   count;
    logic               full;
    logic               do_wr;
    logic               do_rd;

    function automatic logic [ptr_w-1:0] bump(input logic [ptr_w-1:0] p);
        if (p == ptr_w'(fifo_depth - 1)) begin
            return '0;
        end
        return p + ptr_w'(1);
    endfunction

    assign full    = (count == cnt_w'(fifo_depth));
    assign empty   = (count == '0);
    assign do_wr   = wr_en && !full;
    assign do_rd   = rd_en && !empty;  // pop on empty is ignored
    assign rd_data = mem[rd_ptr];  // head shown while not empty

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            overflow <= 1'b0;
        end else begin
            if (do_wr) begin
                wr_ptr <= bump(wr_ptr);
            end
            if (do_rd) begin
                rd_ptr <= bump(rd_ptr);
            end
            case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            if (wr_en && full) begin
                overflow <= 1'b1;  // sticky until reset
            end
        end
    end

    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= wr_data;
        end
    end

endmodule

/* src/keypad_hub.sv */
`timescale 1ns/10ps

module keypad_hub #(
    parameter int debounce_cycles = keypad_pkg::default_debounce_cycles
) (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic [3:0]                      row0,
    input  logic [3:0]                      row1,
    output logic [3:0]                      col0,
    output logic [3:0]                      col1,
    input  logic                            rd_en,
    output logic [keypad_pkg::event_w-1:0]  rd_data,
    output logic                            empty,
    output logic                            overflow
);
    import keypad_pkg::*;

    logic [num_pads-1:0]                 key_valid;
    logic [num_pads-1:0][key_code_w-1:0] key_code;
    logic                                wr_en;
    logic [event_w-1:0]                  wr_data;

    keypad_scanner #(.debounce_cycles(debounce_cycles)) scan0 (
        .clk       (clk),
        .rst_n     (rst_n),
        .row       (row0),
        .col       (col0),
        .key_valid (key_valid[0]),
        .key_code  (key_code[0])
    );

    keypad_scanner #(.debounce_cycles(debounce_cycles)) scan1 (
        .clk       (clk),
        .rst_n     (rst_n),
        .row       (row1),
        .col       (col1),
        .key_valid (key_valid[1]),
        .key_code  (key_code[1])
    );

    key_event_arbiter arb (
        .clk       (clk),
        .rst_n     (rst_n),
        .key_valid (key_valid),
        .key_code  (key_code),
        .wr_en     (wr_en),
        .wr_data   (wr_data)
    );

    key_event_fifo fifo (
        .clk      (clk),
        .rst_n    (rst_n),
        .wr_en    (wr_en),
        .wr_data  (wr_data),
        .rd_en    (rd_en),
        .rd_data  (rd_data),
        .empty    (empty),
        .overflow (overflow)
    );

endmodule

/* verif/keypad_matrix_model.sv */
`timescale 1ns/10ps

module keypad_matrix_model (
    input  logic [3:0]                        col,
    input  logic                              press,
    input  logic [keypad_pkg::key_code_w-1:0] key,
    output logic [3:0]                        row
);
    import keypad_pkg::*;

    // a closed switch ties its row to its column
    always_comb begin
        row = rows_idle;
        if (press && !col[key[1:0]]) begin
            row[key[3:2]] = 1'b0;  // key code is row*4 + col
        end
    end

endmodule

/* verif/keypad_tb.sv */
`timescale 1ns/10ps

module keypad_tb;
    import keypad_pkg::*;

    localparam int tb_debounce = 20;
    localparam int max_cases   = 32;

    logic                  clk;
    logic                  rst_n;
    logic                  rd_en;
    logic                  press0;
    logic                  press1;
    logic [key_code_w-1:0] key0;
    logic [key_code_w-1:0] key1;
    logic [3:0]            row0;
    logic [3:0]            row1;
    logic [3:0]            col0;
    logic [3:0]            col1;
    logic [event_w-1:0]    rd_data;
    logic                  empty;
    logic                  overflow;

    logic [63:0] kind_tab [max_cases];
    int          pad_tab  [max_cases];
    int          key_tab  [max_cases];
    int          hold_tab [max_cases];
    int          nexp_tab [max_cases];
    int          exp_tab  [max_cases][fifo_depth];
    int          num_cases;
    int          limit_cycles;
    logic        limit_ready;

    keypad_hub #(.debounce_cycles(tb_debounce)) dut0 (
        .clk      (clk),
        .rst_n    (rst_n),
        .row0     (row0),
        .row1     (row1),
        .col0     (col0),
        .col1     (col1),
        .rd_en    (rd_en),
        .rd_data  (rd_data),
        .empty    (empty),
        .overflow (overflow)
    );

    keypad_matrix_model pad0 (.col(col0), .press(press0), .key(key0), .row(row0));
    keypad_matrix_model pad1 (.col(col1), .press(press1), .key(key1), .row(row1));

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // budget comes from the case list
    initial begin
        wait (limit_ready === 1'b1);
        repeat (limit_cycles) @(posedge clk);
        $display("watchdog: run did not finish within %0d cycles", limit_cycles);
        $display("=== FAIL ===");
        $fatal(1, "timeout");
    end

    task automatic report_mismatch(input string msg);
        $display("CHECK FAILED at %0t: %s", $time, msg);
        $display("=== FAIL ===");
        $fatal(1, "stopped at first error");
    endtask

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("=== FAIL ===");
        $fatal(1, "stopped at first error");
    endtask

    task automatic apply_reset();
        rst_n = 1'b0;
        repeat (8) @(negedge clk);
        rst_n = 1'b1;
    endtask

    // pad 2 presses the same key on both pads
    task automatic press_key(input int pad, input int key, input int hold);
        @(negedge clk);
        if (pad != 1) begin
            press0 = 1'b1;
            key0   = key_code_w'(key);
        end
        if (pad != 0) begin
            press1 = 1'b1;
            key1   = key_code_w'(key);
        end
        repeat (hold) @(negedge clk);
        press0 = 1'b0;
        press1 = 1'b0;
        repeat (2 + $urandom % 6) @(negedge clk);  // idle gap
    endtask

    task automatic pop_event(output logic [event_w-1:0] ev);
        int n;
        n = 0;
        while (empty && n < 4 * tb_debounce) begin
            @(negedge clk);
            n++;
        end
        if (empty) begin
            abort_run("no event reached the FIFO in time");
        end
        ev    = rd_data;
        rd_en = 1'b1;
        @(negedge clk);
        rd_en = 1'b0;
    endtask

    task automatic expect_quiet(input int cycles);
        repeat (cycles) begin
            @(negedge clk);
            assert (empty) else report_mismatch("unexpected event in the FIFO");
        end
    endtask

    initial begin
        int fd;
        string line;
        logic [63:0] kind;
        int pad, key, hold, nexp, got, presses, n;
        int ev [fifo_depth];
        logic [event_w-1:0] got0;
        logic [event_w-1:0] got1;

        rst_n       = 1'b0;
        rd_en       = 1'b0;
        press0      = 1'b0;
        press1      = 1'b0;
        key0        = '0;
        key1        = '0;
        limit_ready = 1'b0;
        num_cases   = 0;
        limit_cycles = 20;
        void'($urandom(45));

        fd = $fopen("verif/keypad_cases.txt", "r");
        if (fd == 0) begin
            abort_run("cannot open verif/keypad_cases.txt");
        end
        while ($fgets(line, fd) != 0) begin
            got = $sscanf(line, "%s %d %h %d %d %h %h %h %h %h %h %h %h", kind, pad, key,
                          hold, nexp, ev[0], ev[1], ev[2], ev[3], ev[4], ev[5], ev[6], ev[7]);
            if (got < 5) begin
                continue;  // comment or blank
            end
            if (got != 5 + nexp || num_cases == max_cases) begin
                abort_run("malformed or surplus line in the case file");
            end
            kind_tab[num_cases] = kind;
            pad_tab[num_cases]  = pad;
            key_tab[num_cases]  = key;
            hold_tab[num_cases] = hold;
            nexp_tab[num_cases] = nexp;
            for (int j = 0; j < nexp; j++) begin
                exp_tab[num_cases][j] = ev[j];
            end
            presses = (kind == "flood") ? fifo_depth + 2 : ((nexp > 1) ? nexp : 1);
            limit_cycles += presses * (hold + 200) + 100;
            num_cases++;
        end
        $fclose(fd);
        limit_ready = 1'b1;

        apply_reset();
        assert (empty && !overflow && col0 == 4'b0000 && col1 == 4'b0000)
            else report_mismatch("outputs not at their reset values");

        for (int i = 0; i < num_cases; i++) begin
            if (kind_tab[i] == "press") begin
                for (int j = 0; j < nexp_tab[i]; j++) begin
                    press_key(pad_tab[i], key_tab[i] + j, hold_tab[i]);
                    pop_event(got0);
                    assert (got0 == event_w'(exp_tab[i][j])) else report_mismatch(
                        $sformatf("case %0d: got event %h, expected %h", i, got0,
                                  event_w'(exp_tab[i][j])));
                end
            end else if (kind_tab[i] == "short") begin
                press_key(pad_tab[i], key_tab[i], hold_tab[i]);
            end else if (kind_tab[i] == "dual") begin
                press_key(2, key_tab[i], hold_tab[i]);
                pop_event(got0);
                pop_event(got1);
                // order follows the round-robin pointer
                assert ((got0 == event_w'(exp_tab[i][0]) && got1 == event_w'(exp_tab[i][1])) ||
                        (got0 == event_w'(exp_tab[i][1]) && got1 == event_w'(exp_tab[i][0])))
                    else report_mismatch($sformatf("case %0d: events %h %h are not the pair",
                                                   i, got0, got1));
            end else if (kind_tab[i] == "flood") begin
                for (int j = 0; j <= fifo_depth; j++) begin
                    press_key(pad_tab[i], key_tab[i] + j, hold_tab[i]);
                end
                n = 0;
                while (!overflow && n < 4 * tb_debounce) begin
                    @(negedge clk);
                    n++;
                end
                assert (overflow) else report_mismatch("overflow not set by a write to a full FIFO");
                for (int j = 0; j < nexp_tab[i]; j++) begin
                    pop_event(got0);
                    assert (got0 == event_w'(exp_tab[i][j])) else report_mismatch(
                        $sformatf("case %0d: entry %0d is %h, expected %h", i, j, got0,
                                  event_w'(exp_tab[i][j])));
                end
            end else begin
                abort_run($sformatf("unknown case kind on case %0d", i));
            end
            expect_quiet(2 * tb_debounce);
            if (kind_tab[i] == "flood") begin
                press_key(pad_tab[i], key_tab[i], hold_tab[i]);  // left queued
                assert (!empty) else report_mismatch("no event queued ahead of the reset");
                apply_reset();
                assert (!overflow && empty) else report_mismatch("overflow or data left after reset");
            end
        end

        $display("=== PASS ===");
        $finish;
    end

endmodule

/* compile.f */
src/keypad_pkg.sv
src/keypad_scanner.sv
src/key_event_arbiter.sv
src/key_event_fifo.sv
src/keypad_hub.sv
verif/keypad_matrix_model.sv
verif/keypad_tb.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing -Wno-fatal --top-module keypad_tb -f compile.f -o keypad_sim
./obj_dir/keypad_sim

/* verif/keypad_cases.txt */
# kind pad key(hex) hold(cycles) count expected-events(hex, pad*16 + row*4 + col)
# press steps key..key+count-1, dual presses both pads, flood presses key..key+8 unread
press 0 0 40 4 00 01 02 03
press 0 4 40 4 04 05 06 07
press 0 8 40 4 08 09 0a 0b
press 0 c 40 4 0c 0d 0e 0f
press 1 0 40 4 10 11 12 13
press 1 4 40 4 14 15 16 17
press 1 8 40 4 18 19 1a 1b
press 1 c 40 4 1c 1d 1e 1f
short 0 5 12 0
short 1 a 6 0
press 0 9 400 1 09
press 0 9 40 1 09
press 1 f 250 1 1f
dual 2 6 40 2 06 16
dual 2 d 60 2 0d 1d
flood 0 3 40 8 03 04 05 06 07 08 09 0a
flood 1 e 40 8 1e 1f 10 11 12 13 14 15
press 1 2 40 1 12
